// ==== dv/decode_assertions.sv ====
`timescale 1ns/1ps

module decode_assertions (
  input logic                   clk,
  input logic                   rest,
  input logic                   de_valid,
  input logic                   de_ready,
  input logic                   ex_flush,
  input logic                   stall,
  input decode_pkg::de_bundle_t de
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Handshake properties
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_idle_after_reset: assert property (@(posedge clk) $rose(rest) |-> !de_valid)
    else $error("de_valid high in the first cycle after reset");

  // A flush may clear a held bundle
  a_hold_on_backpressure: assert property (@(posedge clk) disable iff (!rest)
    (de_valid && !de_ready && !ex_flush) |=> $stable(de))
    else $error("de changed while held by execute");

  // Open slot during a hazard leaves a bubble
  a_bubble_on_stall: assert property (@(posedge clk) disable iff (!rest)
    (stall && (!de_valid || de_ready)) |=> !de_valid)
    else $error("bundle loaded during a hazard stall");

endmodule

bind decode_stage decode_assertions u_decode_assertions (
  .clk      (clk),
  .rest     (rest),
  .de_valid (de_valid),
  .de_ready (de_ready),
  .ex_flush (ex_flush),
  .stall    (stall),
  .de       (de)
);

// ==== dv/tb_decode.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module tb_decode;
  import decode_pkg::*;

  localparam int TIMEOUT = 20;  // Cycles per bounded wait

  logic       clk;
  logic       rest;
  logic       fd_valid;
  logic       fd_ready;
  fetch_t     fd;
  logic       de_valid;
  logic       de_ready;
  de_bundle_t de;
  logic       wb_valid;
  wb_t        wb;
  logic       ex_flush;
  stage_dst_t ex_dst;
  stage_dst_t em_dst;

  string                test_name;
  int unsigned          test_errors;
  int unsigned          pass_count;
  int unsigned          fail_count;
  logic [31:0]          rng_state;
  logic [`DEC_XLEN-1:0] exp_regs [`DEC_NUM_REGS];  // Register file model

  decode_stage u_decode_stage (.*);

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encoders and expected controls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP_RA, 2'b11};
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e op);
    return {imm[11:0], rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_SD, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL, 2'b11};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] upper, input logic [4:0] rd,
                                        input opcode_e op);
    return {upper, rd, op, 2'b11};
  endfunction

  // Flags are reg_write, mem_read, mem_write, is_br, rs1_used, rs2_used
  function automatic ctrl_t make_ctrl(input alu_op_e alu, input br_op_e br, input mem_op_e mem,
                                      input alu_a_sel_e a_sel, input alu_b_sel_e b_sel,
                                      input wb_sel_e w_sel, input logic [5:0] flags);
    ctrl_t c;
    c = '{alu_op: alu, br_op: br, mem_op: mem, alu_a_sel: a_sel, alu_b_sel: b_sel,
          wb_sel: w_sel, reg_write: flags[5], mem_read: flags[4], mem_write: flags[3],
          is_br: flags[2], rs1_used: flags[1], rs2_used: flags[0]};
    return c;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_random(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value = rng_state;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_ctrl(input string label, input ctrl_t exp, input ctrl_t act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, label, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_word(input string label, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, label, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_reg(input string label, input logic [`DEC_REG_W-1:0] exp,
                           input logic [`DEC_REG_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected x%0d, actual x%0d", test_name, label, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string label, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s %s: expected %b, actual %b", test_name, label, exp, act);
      test_errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive point after the edge
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("[TEST] %s done, no errors", test_name);
    end else begin
      fail_count++;
      $display("[TEST] %s done, %0d errors", test_name, test_errors);
    end
  endtask

  // Holds fd_valid until the handshake edge, then drops it and any strobe
  task automatic send_instr(input string label, input logic [31:0] instr,
                            input logic [31:0] pc);
    int waited;
    waited   = 0;
    fd_valid = 1'b1;
    fd       = '{pc: pc, instr: instr, jump: 1'b0};
    @(negedge clk);
    while (!fd_ready && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!fd_ready) begin
      $display("%s %s: timeout, the instruction was never accepted", test_name, label);
      test_errors++;
    end
    next_cycle();
    fd_valid = 1'b0;
    wb_valid = 1'b0;
  endtask

  // Called just after the acceptance edge, so one cycle means no extra wait
  task automatic wait_de_valid(input string label);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!de_valid && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!de_valid) begin
      $display("%s %s: timeout, no valid bundle reached execute", test_name, label);
      test_errors++;
    end else if (waited != 0) begin
      $display("[ERROR] %s %s latency: expected 1 cycle, actual %0d cycles",
               test_name, label, waited + 1);
      test_errors++;
    end
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
    wb_valid = 1'b1;
    wb       = '{rd: rd, data: data};
    if (rd != 5'd0) begin
      exp_regs[rd] = data;
    end
    next_cycle();
    wb_valid = 1'b0;
  endtask

  task automatic run_decode(input string label, input logic [31:0] instr,
                            input ctrl_t exp_ctrl, input logic [31:0] exp_imm);
    send_instr(label, instr, 32'h0000_0100);
    wait_de_valid(label);
    check_ctrl(label, exp_ctrl, de.ctrl);
    check_word({label, " imm"}, exp_imm, de.imm);
    next_cycle();  // Slot drains
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_alu_decode();
    start_test("alu_decode");
    run_decode("add", enc_r(`DEC_F7_BASE, 5'd2, 5'd1, `DEC_F3_ADD, 5'd3),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_B, A_RS1, B_RS2, WB_ALU, 6'b100011), 32'd0);
    run_decode("sub", enc_r(`DEC_F7_ALT, 5'd2, 5'd1, `DEC_F3_ADD, 5'd3),
               make_ctrl(ALU_SUB, BR_FALSE, MEM_B, A_RS1, B_RS2, WB_ALU, 6'b100011), 32'd0);
    run_decode("sra", enc_r(`DEC_F7_ALT, 5'd4, 5'd1, `DEC_F3_SRL, 5'd3),
               make_ctrl(ALU_SRA, BR_FALSE, MEM_B, A_RS1, B_RS2, WB_ALU, 6'b100011), 32'd0);
    run_decode("addi", enc_i(-32'sd3, 5'd1, `DEC_F3_ADD, 5'd5, OP_IA),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_B, A_RS1, B_IMM, WB_ALU, 6'b100010),
               32'hFFFF_FFFD);
    run_decode("sltiu", enc_i(32'd100, 5'd2, `DEC_F3_SLTU, 5'd6, OP_IA),
               make_ctrl(ALU_SLTU, BR_FALSE, MEM_B, A_RS1, B_IMM, WB_ALU, 6'b100010), 32'd100);
    run_decode("slli", enc_i(32'd5, 5'd1, `DEC_F3_SLL, 5'd7, OP_IA),
               make_ctrl(ALU_SLL, BR_FALSE, MEM_B, A_RS1, B_IMM, WB_ALU, 6'b100010), 32'd5);
    run_decode("add x0", enc_r(`DEC_F7_BASE, 5'd2, 5'd1, `DEC_F3_ADD, 5'd0),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_B, A_RS1, B_RS2, WB_ALU, 6'b000011), 32'd0);
    finish_test();
  endtask

  task automatic test_reg_file();
    logic [31:0] value;
    start_test("reg_file");
    for (int r = 0; r < 5; r++) begin
      next_random(value);
      write_reg(5'(r), value);  // x0 write must be dropped
    end
    send_instr("x1 x2", enc_r(`DEC_F7_BASE, 5'd2, 5'd1, `DEC_F3_ADD, 5'd5), 32'h0000_0200);
    wait_de_valid("x1 x2");
    check_word("rs1_value x1", exp_regs[1], de.rs1_value);
    check_word("rs2_value x2", exp_regs[2], de.rs2_value);
    check_reg("rd field", 5'd5, de.rd);
    check_reg("rs1 field", 5'd1, de.rs1);
    check_reg("rs2 field", 5'd2, de.rs2);
    check_bit("jump flag", 1'b0, de.jump);
    next_cycle();
    send_instr("x0 x3", enc_r(`DEC_F7_BASE, 5'd3, 5'd0, `DEC_F3_ADD, 5'd5), 32'h0000_0204);
    wait_de_valid("x0 x3");
    check_word("rs1_value x0", 32'd0, de.rs1_value);
    check_word("rs2_value x3", exp_regs[3], de.rs2_value);
    next_cycle();
    next_random(value);
    wb_valid    = 1'b1;  // Strobe lands on the acceptance edge
    wb          = '{rd: 5'd4, data: value};
    exp_regs[4] = value;
    send_instr("write first", enc_r(`DEC_F7_BASE, 5'd4, 5'd4, `DEC_F3_ADD, 5'd6),
               32'h0000_0208);
    wait_de_valid("write first");
    check_word("rs1_value x4", exp_regs[4], de.rs1_value);
    check_word("rs2_value x4", exp_regs[4], de.rs2_value);
    next_cycle();
    finish_test();
  endtask

  task automatic test_mem_control();
    start_test("mem_control");
    run_decode("lb", enc_i(-32'sd4, 5'd1, `DEC_F3_MEM_B, 5'd8, OP_LD),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_B, A_RS1, B_IMM, WB_ALU, 6'b110010),
               32'hFFFF_FFFC);
    run_decode("lhu", enc_i(32'd6, 5'd2, `DEC_F3_MEM_HU, 5'd9, OP_LD),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_HU, A_RS1, B_IMM, WB_ALU, 6'b110010), 32'd6);
    run_decode("sw", enc_s(-32'sd12, 5'd3, 5'd4, `DEC_F3_MEM_W),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_W, A_RS1, B_IMM, WB_ALU, 6'b001011),
               32'hFFFF_FFF4);
    run_decode("beq", enc_b(-32'sd16, 5'd2, 5'd1, `DEC_F3_BEQ),
               make_ctrl(ALU_ADD, BR_EQ, MEM_B, A_PC, B_IMM, WB_ALU, 6'b000111),
               32'hFFFF_FFF0);
    run_decode("bgeu", enc_b(32'd2048, 5'd4, 5'd3, `DEC_F3_BGEU),
               make_ctrl(ALU_ADD, BR_GEU, MEM_B, A_PC, B_IMM, WB_ALU, 6'b000111), 32'd2048);
    run_decode("jal", enc_j(-32'sd262144, 5'd1),
               make_ctrl(ALU_ADD, BR_TRUE, MEM_B, A_PC, B_IMM, WB_PC_NEXT, 6'b100100),
               32'hFFFC_0000);
    run_decode("jalr", enc_i(32'd8, 5'd5, 3'b000, 5'd1, OP_JALR),
               make_ctrl(ALU_ADD, BR_TRUE, MEM_B, A_RS1, B_IMM, WB_PC_NEXT, 6'b100110), 32'd8);
    run_decode("lui", enc_u(20'hFFFFF, 5'd10, OP_LUI),
               make_ctrl(ALU_NOP, BR_FALSE, MEM_B, A_RS1, B_IMM, WB_IMM, 6'b100000),
               32'hFFFF_F000);
    run_decode("auipc", enc_u(20'h12345, 5'd11, OP_AUIPC),
               make_ctrl(ALU_ADD, BR_FALSE, MEM_B, A_PC, B_IMM, WB_ALU, 6'b100000),
               32'h1234_5000);
    finish_test();
  endtask

  task automatic test_load_use();
    start_test("load_use");
    em_dst   = '{rd: 5'd1, reg_write: 1'b1, mem_read: 1'b1};  // Load to x1 in memory stage
    fd_valid = 1'b1;
    fd       = '{pc: 32'h0000_0300, instr: enc_r(`DEC_F7_BASE, 5'd2, 5'd1, `DEC_F3_ADD, 5'd5),
                 jump: 1'b0};
    repeat (3) begin
      @(negedge clk);
      check_bit("fd_ready in stall", 1'b0, fd_ready);
      check_bit("de_valid in stall", 1'b0, de_valid);
    end
    next_cycle();
    em_dst = '0;
    send_instr("after stall", fd.instr, fd.pc);
    wait_de_valid("after stall");
    check_word("pc after stall", 32'h0000_0300, de.pc);
    next_cycle();
    ex_dst   = '{rd: 5'd2, reg_write: 1'b1, mem_read: 1'b1};
    fd_valid = 1'b1;
    fd       = '{pc: 32'h0000_0304, instr: enc_s(32'd0, 5'd2, 5'd1, `DEC_F3_MEM_W),
                 jump: 1'b1};
    @(negedge clk);
    check_bit("store fd_ready", 1'b1, fd_ready);  // rs2 data is forwarded
    next_cycle();
    fd_valid = 1'b0;
    wait_de_valid("store");
    check_word("store pc", 32'h0000_0304, de.pc);
    check_bit("store jump", 1'b1, de.jump);
    next_cycle();
    ex_dst = '0;
    finish_test();
  endtask

  task automatic test_backpressure_flush();
    start_test("backpressure_flush");
    de_ready = 1'b0;
    send_instr("first", enc_i(32'd1, 5'd2, `DEC_F3_ADD, 5'd1, OP_IA), 32'h0000_0400);
    wait_de_valid("first");
    next_cycle();
    fd_valid = 1'b1;
    fd       = '{pc: 32'h0000_0404, instr: enc_i(32'd2, 5'd4, `DEC_F3_ADD, 5'd3, OP_IA),
                 jump: 1'b0};
    repeat (2) begin
      @(negedge clk);
      check_bit("fd_ready when full", 1'b0, fd_ready);
      check_bit("de_valid when full", 1'b1, de_valid);
      check_word("held pc", 32'h0000_0400, de.pc);
    end
    next_cycle();
    ex_flush = 1'b1;
    fd_valid = 1'b0;
    next_cycle();
    ex_flush = 1'b0;
    de_ready = 1'b1;
    @(negedge clk);
    check_bit("de_valid after flush", 1'b0, de_valid);
    next_cycle();
    finish_test();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clk         = 1'b0;
    rest        = 1'b0;
    fd_valid    = 1'b0;
    fd          = '0;
    de_ready    = 1'b1;
    wb_valid    = 1'b0;
    wb          = '0;
    ex_flush    = 1'b0;
    ex_dst      = '0;
    em_dst      = '0;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    rng_state   = 32'd81848;
    exp_regs[0] = '0;
    repeat (2) @(posedge clk);
    #1 rest = 1'b1;
    next_cycle();
    test_alu_decode();
    test_reg_file();
    test_mem_control();
    test_load_use();
    test_backpressure_flush();
    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #200000;  // Whole-run limit
    $display("Simulation did not finish in time, stopping");
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+source
source/decode_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/hazard_unit.sv
source/decode_stage.sv
dv/decode_assertions.sv
dv/tb_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_decode -f project.f --Mdir "$MDIR" -o sim_tb_decode
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$MDIR/sim_tb_decode" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0

// ==== source/decode_pkg.sv ====
`include "decode_settings.svh"

package decode_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [4:0] {
    OP_LD    = 5'b00000,
    OP_IA    = 5'b00100,
    OP_AUIPC = 5'b00101,
    OP_SD    = 5'b01000,
    OP_RA    = 5'b01100,
    OP_LUI   = 5'b01101,
    OP_BR    = 5'b11000,
    OP_JALR  = 5'b11001,
    OP_JAL   = 5'b11011
  } opcode_e;  // Bits 6:2 of the instruction

  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_FALSE, BR_TRUE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } br_op_e;

  typedef enum logic [2:0] {
    MEM_B = 3'd0, MEM_H = 3'd1, MEM_W = 3'd2, MEM_BU = 3'd4, MEM_HU = 3'd5
  } mem_op_e;  // Same values as the funct3 field

  typedef enum logic {A_RS1, A_PC} alu_a_sel_e;
  typedef enum logic {B_RS2, B_IMM} alu_b_sel_e;
  typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_PC_NEXT} wb_sel_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`DEC_XLEN-1:0] pc;
    logic [`DEC_ILEN-1:0] instr;
    logic                 jump;   // Already redirected by fetch
  } fetch_t;

  typedef struct packed {
    alu_op_e    alu_op;
    br_op_e     br_op;
    mem_op_e    mem_op;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    wb_sel_e    wb_sel;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    logic       is_br;
    logic       rs1_used;
    logic       rs2_used;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`DEC_XLEN-1:0]  pc;
    logic [`DEC_XLEN-1:0]  imm;
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_REG_W-1:0] rs1;
    logic [`DEC_REG_W-1:0] rs2;
    logic [`DEC_XLEN-1:0]  rs1_value;
    logic [`DEC_XLEN-1:0]  rs2_value;
    logic                  jump;
  } de_bundle_t;

  typedef struct packed {
    logic [`DEC_REG_W-1:0] rd;
    logic [`DEC_XLEN-1:0]  data;
  } wb_t;

  typedef struct packed {
    logic [`DEC_REG_W-1:0] rd;
    logic                  reg_write;
    logic                  mem_read;
  } stage_dst_t;  // Hazard view of a later stage

  localparam ctrl_t CTRL_NOP = '{alu_op: ALU_NOP, br_op: BR_FALSE, mem_op: MEM_B,
                                alu_a_sel: A_RS1, alu_b_sel: B_RS2, wb_sel: WB_ALU,
                                default: 1'b0};

endpackage

// ==== source/decode_settings.svh ====
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DEC_XLEN      32
`define DEC_ILEN      32
`define DEC_REG_W     5
`define DEC_NUM_REGS  32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// funct3 and funct7 codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DEC_F3_ADD    3'b000  // ADD, SUB, ADDI
`define DEC_F3_SLL    3'b001
`define DEC_F3_SLT    3'b010
`define DEC_F3_SLTU   3'b011
`define DEC_F3_XOR    3'b100
`define DEC_F3_SRL    3'b101  // SRL, SRA and immediate forms
`define DEC_F3_OR     3'b110
`define DEC_F3_AND    3'b111

`define DEC_F3_MEM_B  3'b000
`define DEC_F3_MEM_H  3'b001
`define DEC_F3_MEM_W  3'b010
`define DEC_F3_MEM_BU 3'b100
`define DEC_F3_MEM_HU 3'b101

`define DEC_F3_BEQ    3'b000
`define DEC_F3_BNE    3'b001
`define DEC_F3_BLT    3'b100
`define DEC_F3_BGE    3'b101
`define DEC_F3_BLTU   3'b110
`define DEC_F3_BGEU   3'b111

`define DEC_F7_BASE   7'b0000000
`define DEC_F7_ALT    7'b0100000  // SUB, SRA, SRAI

`endif

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rest,
  input  logic                   fd_valid,
  output logic                   fd_ready,
  input  decode_pkg::fetch_t     fd,
  output logic                   de_valid,
  input  logic                   de_ready,
  output decode_pkg::de_bundle_t de,
  input  logic                   wb_valid,
  input  decode_pkg::wb_t        wb,
  input  logic                   ex_flush,
  input  decode_pkg::stage_dst_t ex_dst,
  input  decode_pkg::stage_dst_t em_dst
);
  import decode_pkg::*;

  ctrl_t                 dec_ctrl;
  logic [`DEC_XLEN-1:0]  dec_imm;
  logic [`DEC_REG_W-1:0] fd_rd;
  logic [`DEC_REG_W-1:0] fd_rs1;
  logic [`DEC_REG_W-1:0] fd_rs2;
  logic                  stall;
  logic                  slot_open;
  logic                  accept;
  stage_dst_t            own_dst;
  stage_dst_t            near_dst;
  logic [`DEC_XLEN-1:0]  rf_rs1_value;
  logic [`DEC_XLEN-1:0]  rf_rs2_value;

  ctrl_t                 de_ctrl_q;
  logic [`DEC_XLEN-1:0]  de_pc_q;
  logic [`DEC_XLEN-1:0]  de_imm_q;
  logic [`DEC_REG_W-1:0] de_rd_q;
  logic [`DEC_REG_W-1:0] de_rs1_q;
  logic [`DEC_REG_W-1:0] de_rs2_q;
  logic                  de_jump_q;

  assign fd_rd  = fd.instr[11:7];
  assign fd_rs1 = fd.instr[19:15];
  assign fd_rs2 = fd.instr[24:20];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode and hazard check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  instr_decoder u_instr_decoder (
    .instr (fd.instr),
    .ctrl  (dec_ctrl),
    .imm   (dec_imm)
  );

  // Held instruction is the nearest older one, else the execute stage
  assign own_dst  = '{rd: de_rd_q, reg_write: de_ctrl_q.reg_write,
                      mem_read: de_ctrl_q.mem_read};
  assign near_dst = de_valid ? own_dst : ex_dst;

  hazard_unit u_hazard_unit (
    .rs1    (fd_rs1),
    .rs2    (fd_rs2),
    .ctrl   (dec_ctrl),
    .ex_dst (near_dst),
    .em_dst (em_dst),
    .stall  (stall)
  );

  assign slot_open = !de_valid || de_ready;  // Empty or draining
  assign fd_ready  = slot_open && !stall;
  assign accept    = fd_valid && fd_ready;

  reg_file u_reg_file (
    .clk       (clk),
    .read_en   (accept),  // Operands read on the load edge
    .rs1       (fd_rs1),
    .rs2       (fd_rs2),
    .rs1_value (rf_rs1_value),
    .rs2_value (rf_rs2_value),
    .wb_valid  (wb_valid),
    .wb        (wb)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      de_valid  <= 1'b0;
      de_ctrl_q <= CTRL_NOP;
    end else if (ex_flush) begin  // Flush wins over a load
      de_valid  <= 1'b0;
      de_ctrl_q <= CTRL_NOP;
    end else if (slot_open) begin
      de_valid  <= accept;  // Bubble on stall or empty fetch
      de_ctrl_q <= accept ? dec_ctrl : CTRL_NOP;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      de_pc_q   <= fd.pc;
      de_imm_q  <= dec_imm;
      de_rd_q   <= fd_rd;
      de_rs1_q  <= fd_rs1;
      de_rs2_q  <= fd_rs2;
      de_jump_q <= fd.jump;
    end
  end

  assign de = '{ctrl: de_ctrl_q, pc: de_pc_q, imm: de_imm_q, rd: de_rd_q,
                rs1: de_rs1_q, rs2: de_rs2_q, rs1_value: rf_rs1_value,
                rs2_value: rf_rs2_value, jump: de_jump_q};

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module hazard_unit (
  input  logic [`DEC_REG_W-1:0] rs1,
  input  logic [`DEC_REG_W-1:0] rs2,
  input  decode_pkg::ctrl_t     ctrl,
  input  decode_pkg::stage_dst_t ex_dst,
  input  decode_pkg::stage_dst_t em_dst,
  output logic                  stall
);

  logic ex_load;
  logic em_load;
  logic rs1_ex;
  logic rs2_ex;
  logic rs1_em;
  logic rs2_em;

  assign ex_load = ex_dst.reg_write && ex_dst.mem_read;
  assign em_load = em_dst.reg_write && em_dst.mem_read;

  assign rs1_ex = ctrl.rs1_used && ex_load && (rs1 == ex_dst.rd);
  assign rs2_ex = ctrl.rs2_used && ex_load && (rs2 == ex_dst.rd);
  assign rs1_em = ctrl.rs1_used && em_load && (rs1 == em_dst.rd);
  assign rs2_em = ctrl.rs2_used && em_load && (rs2 == em_dst.rd);

  // Store data against the execute load is forwarded later
  assign stall = rs1_ex || rs1_em || rs2_em || (rs2_ex && !ctrl.mem_write);

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module instr_decoder (
  input  logic [`DEC_ILEN-1:0] instr,
  output decode_pkg::ctrl_t    ctrl,
  output logic [`DEC_XLEN-1:0] imm
);
  import decode_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`DEC_REG_W-1:0] rd;
  logic                  f7_alt;
  logic                  ra_ok;
  logic                  ia_ok;
  logic [`DEC_XLEN-1:0]  imm_i;
  logic [`DEC_XLEN-1:0]  imm_s;
  logic [`DEC_XLEN-1:0]  imm_b;
  logic [`DEC_XLEN-1:0]  imm_j;
  logic [`DEC_XLEN-1:0]  imm_u;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      `DEC_F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      `DEC_F3_SLL:  return ALU_SLL;
      `DEC_F3_SLT:  return ALU_SLT;
      `DEC_F3_SLTU: return ALU_SLTU;
      `DEC_F3_XOR:  return ALU_XOR;
      `DEC_F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
      `DEC_F3_OR:   return ALU_OR;
      default:      return ALU_AND;
    endcase
  endfunction

  function automatic mem_op_e mem_from_f3(input logic [2:0] f3);
    case (f3)
      `DEC_F3_MEM_B:  return MEM_B;
      `DEC_F3_MEM_H:  return MEM_H;
      `DEC_F3_MEM_BU: return MEM_BU;
      `DEC_F3_MEM_HU: return MEM_HU;
      default:        return MEM_W;
    endcase
  endfunction

  function automatic br_op_e br_from_f3(input logic [2:0] f3);
    case (f3)
      `DEC_F3_BEQ:  return BR_EQ;
      `DEC_F3_BNE:  return BR_NE;
      `DEC_F3_BLT:  return BR_LT;
      `DEC_F3_BGE:  return BR_GE;
      `DEC_F3_BLTU: return BR_LTU;
      `DEC_F3_BGEU: return BR_GEU;
      default:      return BR_FALSE;  // Reserved codes never taken
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fields and immediates
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode = opcode_e'(instr[6:2]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign f7_alt = funct7 == `DEC_F7_ALT;

  // Alternate funct7 only exists for SUB and SRA
  assign ra_ok = (funct7 == `DEC_F7_BASE) ||
                 (f7_alt && (funct3 == `DEC_F3_ADD || funct3 == `DEC_F3_SRL));
  // Shift immediates carry funct7 in the upper immediate bits
  assign ia_ok = !(funct3 == `DEC_F3_SLL || funct3 == `DEC_F3_SRL) ||
                 (funct7 == `DEC_F7_BASE) || (f7_alt && funct3 == `DEC_F3_SRL);

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ctrl = CTRL_NOP;
    imm  = '0;
    if (instr[1:0] == 2'b11) begin  // Full-width encodings only
      case (opcode)
        OP_RA: begin
          if (ra_ok) begin
            ctrl.alu_op    = alu_from_f3(funct3, f7_alt);
            ctrl.reg_write = 1'b1;
            ctrl.rs1_used  = 1'b1;
            ctrl.rs2_used  = 1'b1;
          end
        end
        OP_IA: begin
          if (ia_ok) begin
            ctrl.alu_op    = alu_from_f3(funct3, f7_alt && funct3 == `DEC_F3_SRL);
            ctrl.alu_b_sel = B_IMM;
            ctrl.reg_write = 1'b1;
            ctrl.rs1_used  = 1'b1;
            imm            = imm_i;
          end
        end
        OP_LD: begin
          ctrl.alu_op    = ALU_ADD;  // Address is rs1 + offset
          ctrl.alu_b_sel = B_IMM;
          ctrl.mem_op    = mem_from_f3(funct3);
          ctrl.mem_read  = 1'b1;
          ctrl.reg_write = 1'b1;
          ctrl.rs1_used  = 1'b1;
          imm            = imm_i;
        end
        OP_SD: begin
          ctrl.alu_op    = ALU_ADD;
          ctrl.alu_b_sel = B_IMM;
          ctrl.mem_op    = mem_from_f3(funct3);
          ctrl.mem_write = 1'b1;
          ctrl.rs1_used  = 1'b1;
          ctrl.rs2_used  = 1'b1;  // Store data
          imm            = imm_s;
        end
        OP_BR: begin
          ctrl.alu_op    = ALU_ADD;  // Target is pc + offset
          ctrl.alu_a_sel = A_PC;
          ctrl.alu_b_sel = B_IMM;
          ctrl.br_op     = br_from_f3(funct3);
          ctrl.is_br     = 1'b1;
          ctrl.rs1_used  = 1'b1;
          ctrl.rs2_used  = 1'b1;
          imm            = imm_b;
        end
        OP_JAL: begin
          ctrl.alu_op    = ALU_ADD;
          ctrl.alu_a_sel = A_PC;
          ctrl.alu_b_sel = B_IMM;
          ctrl.br_op     = BR_TRUE;
          ctrl.is_br     = 1'b1;
          ctrl.wb_sel    = WB_PC_NEXT;  // Link address
          ctrl.reg_write = 1'b1;
          imm            = imm_j;
        end
        OP_JALR: begin
          ctrl.alu_op    = ALU_ADD;
          ctrl.alu_b_sel = B_IMM;
          ctrl.br_op     = BR_TRUE;
          ctrl.is_br     = 1'b1;
          ctrl.wb_sel    = WB_PC_NEXT;
          ctrl.reg_write = 1'b1;
          ctrl.rs1_used  = 1'b1;
          imm            = imm_i;
        end
        OP_LUI: begin
          ctrl.alu_b_sel = B_IMM;
          ctrl.wb_sel    = WB_IMM;  // ALU idle, immediate written directly
          ctrl.reg_write = 1'b1;
          imm            = imm_u;
        end
        OP_AUIPC: begin
          ctrl.alu_op    = ALU_ADD;
          ctrl.alu_a_sel = A_PC;
          ctrl.alu_b_sel = B_IMM;
          ctrl.reg_write = 1'b1;
          imm            = imm_u;
        end
        default: begin
          ctrl = CTRL_NOP;
        end
      endcase
    end
    ctrl.reg_write = ctrl.reg_write && (rd != '0);  // x0 is never a destination
  end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "decode_settings.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  read_en,
  input  logic [`DEC_REG_W-1:0] rs1,
  input  logic [`DEC_REG_W-1:0] rs2,
  output logic [`DEC_XLEN-1:0]  rs1_value,
  output logic [`DEC_XLEN-1:0]  rs2_value,
  input  logic                  wb_valid,
  input  decode_pkg::wb_t       wb
);

  logic [`DEC_XLEN-1:0] regs [`DEC_NUM_REGS];

  // Write-first lookup, x0 hardwired to zero
  function automatic logic [`DEC_XLEN-1:0] read_port(input logic [`DEC_REG_W-1:0] addr);
    logic [`DEC_XLEN-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (wb_valid && wb.rd == addr) begin
      value = wb.data;  // Bypass same-edge write
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (wb_valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (read_en) begin  // Outputs hold while disabled
      rs1_value <= read_port(rs1);
      rs2_value <= read_port(rs2);
    end
  end

endmodule
